/* common/gmii_rx_pkg.sv */
package gmii_rx_pkg;

	// --------------------
	// Packet kinds
	// --------------------

	// Info byte at off_info
	typedef enum logic [7:0] {
		kind_video = 8'd0,
		kind_audio = 8'd1,
		kind_vidax = 8'd2
	} pkt_kind_t;

	// --------------------
	// Stream words
	// --------------------

	// One received byte with its payload tags
	typedef struct packed {
		logic [7:0] data;
		logic       video_byte;
		logic       aux_byte;
		logic       aux_start;
		logic       frame_end;
	} rx_beat_t;

	// Line prologue of a video frame
	typedef struct packed {
		logic [10:0] line;
		logic        odd;
	} line_info_t;

	typedef struct packed {
		logic        odd;
		logic [10:0] line;
		logic [15:0] pixels;
	} pixel_word_t;

	typedef struct packed {
		logic [11:0] chan_id;
		logic [11:0] sample;
	} aux_word_t;

	// --------------------
	// Header layout
	// --------------------

	// Byte offsets counted from the first preamble byte
	localparam logic [10:0] off_eth_type = 11'h14;
	localparam logic [10:0] off_ip_ver   = 11'h16;
	localparam logic [10:0] off_ip_proto = 11'h1f;
	localparam logic [10:0] off_ip_dst   = 11'h26;
	localparam logic [10:0] off_udp_dst  = 11'h2c;
	localparam logic [10:0] off_info     = 11'h32;
	localparam logic [10:0] off_payload  = 11'h33;

	// Accepted protocol values
	localparam logic [15:0] eth_type_ipv4 = 16'h0800;
	localparam logic [7:0]  ip_ver_ihl5   = 8'h45;
	localparam logic [7:0]  ip_proto_udp  = 8'd17;

	// Sample bytes per audio block hold 32 samples
	localparam int aux_block_bytes = 48;

endpackage

/* source/sync_fifo.sv */
`timescale 1ns/10ps

module sync_fifo #(
	parameter int width = 28,
	parameter int depth = 512
) (
	input  logic             clk125,
	input  logic             sys_rst,
	input  logic             wr_en,
	input  logic [width-1:0] wr_data,
	input  logic             rd_en,
	output logic [width-1:0] rd_data,
	output logic             empty,
	output logic             overflow
);

	localparam int aw = $clog2(depth);

	logic [width-1:0] mem [depth];
	logic [aw-1:0]    wr_ptr;
	logic [aw-1:0]    rd_ptr;
	logic [aw:0]      count;
	logic             full;
	logic             do_wr;
	logic             do_rd;

	assign full    = count == (aw + 1)'(depth);
	assign empty   = count == '0;
	assign do_wr   = wr_en && !full;
	assign do_rd   = rd_en && !empty;
	// First-word-fall-through head word
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (aw + 1)'(do_wr) - (aw + 1)'(do_rd);
			// Sticky until reset
			if (wr_en && full)
				overflow <= 1'b1;
		end
	end

	always_ff @(posedge clk125) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	assert property (@(posedge clk125) disable iff (sys_rst) !(rd_en && empty));

endmodule

/* source/udp_header_match.sv */
`timescale 1ns/10ps

module udp_header_match import gmii_rx_pkg::*; #(
	parameter logic [31:0] local_ip   = {8'd192, 8'd168, 8'd0, 8'd1},
	parameter logic [15:0] local_port = 16'd12345,
	parameter int          video_end  = 1332
) (
	input  logic       clk125,
	input  logic       sys_rst,
	input  logic [7:0] rxd,
	input  logic       rx_dv,
	input  logic       id,
	output rx_beat_t   beat,
	output line_info_t line_out
);

	logic [10:0] rx_count;
	logic        dv_q;
	logic        matched;
	pkt_kind_t   kind;

	logic [15:0] eth_type;
	logic [7:0]  ip_ver;
	logic [7:0]  ip_proto;
	logic [31:0] ip_dst;
	logic [15:0] udp_dst;

	logic hdr_ok;
	logic vid_kind;
	logic video_tag;
	logic aux_tag;
	logic aux_start_tag;

	// Board select raises the last address octet
	assign hdr_ok = eth_type == eth_type_ipv4 && ip_ver == ip_ver_ihl5 &&
		ip_proto == ip_proto_udp && udp_dst == local_port &&
		ip_dst == {local_ip[31:8], local_ip[7:0] + {7'd0, id}};

	assign vid_kind = kind == kind_video || kind == kind_vidax;

	// --------------------
	// Payload tags
	// --------------------

	assign video_tag = rx_dv && matched && vid_kind &&
		rx_count >= off_payload + 11'd2 && rx_count < 11'(video_end);
	assign aux_tag = rx_dv && matched &&
		((kind == kind_audio && rx_count >= off_payload) ||
		(kind == kind_vidax && rx_count >= 11'(video_end)));
	assign aux_start_tag = rx_dv && matched &&
		((kind == kind_audio && rx_count == off_payload) ||
		(kind == kind_vidax && rx_count == 11'(video_end)));

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			rx_count <= '0;
			dv_q     <= 1'b0;
			matched  <= 1'b0;
			kind     <= kind_video;
			beat     <= '0;
		end else begin
			dv_q            <= rx_dv;
			beat.data       <= rxd;
			beat.video_byte <= video_tag;
			beat.aux_byte   <= aux_tag;
			beat.aux_start  <= aux_start_tag;
			beat.frame_end  <= dv_q && !rx_dv;
			if (rx_dv) begin
				// Hold at the top so long frames do not wrap into the header
				if (rx_count != '1)
					rx_count <= rx_count + 11'd1;
				if (rx_count == off_info) begin
					kind    <= pkt_kind_t'(rxd);
					matched <= hdr_ok && (rxd == kind_video || rxd == kind_audio ||
						rxd == kind_vidax);
				end
			end else begin
				rx_count <= '0;
				matched  <= 1'b0;
			end
		end
	end

	// --------------------
	// Field capture
	// --------------------

	always_ff @(posedge clk125) begin
		if (rx_dv) begin
			case (rx_count)
				off_eth_type:         eth_type[15:8] <= rxd;
				off_eth_type + 11'd1: eth_type[7:0]  <= rxd;
				off_ip_ver:           ip_ver         <= rxd;
				off_ip_proto:         ip_proto       <= rxd;
				off_ip_dst:           ip_dst[31:24]  <= rxd;
				off_ip_dst + 11'd1:   ip_dst[23:16]  <= rxd;
				off_ip_dst + 11'd2:   ip_dst[15:8]   <= rxd;
				off_ip_dst + 11'd3:   ip_dst[7:0]    <= rxd;
				off_udp_dst:          udp_dst[15:8]  <= rxd;
				off_udp_dst + 11'd1:  udp_dst[7:0]   <= rxd;
				default: ;
			endcase
			// Line prologue of accepted video frames
			if (matched && vid_kind && rx_count == off_payload)
				line_out.line[7:0] <= rxd;
			if (matched && vid_kind && rx_count == off_payload + 11'd1) begin
				line_out.line[10:8] <= rxd[2:0];
				line_out.odd        <= rxd[4];
			end
		end
	end

	assert property (@(posedge clk125) disable iff (sys_rst)
		!(beat.video_byte && beat.aux_byte));
	assert property (@(posedge clk125) disable iff (sys_rst)
		beat.aux_start |-> beat.aux_byte);

endmodule

/* video/video_packer.sv */
`timescale 1ns/10ps

module video_packer import gmii_rx_pkg::*; (
	input  logic        clk125,
	input  logic        sys_rst,
	input  rx_beat_t    beat,
	input  line_info_t  line_in,
	output logic        wr_en,
	output pixel_word_t wr_data
);

	// Low while waiting for the first byte of a pair
	logic       phase;
	logic [7:0] hi_byte;

	// --------------------
	// Pair assembly
	// --------------------

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			phase <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (beat.frame_end || !beat.video_byte) begin
				phase <= 1'b0;
			end else if (!phase) begin
				phase <= 1'b1;
			end else begin
				phase <= 1'b0;
				wr_en <= 1'b1;
			end
		end
	end

	// Word contents follow the same pair phase
	always_ff @(posedge clk125) begin
		if (beat.video_byte && !phase)
			hi_byte <= beat.data;
		if (beat.video_byte && phase) begin
			wr_data.odd    <= line_in.odd;
			wr_data.line   <= line_in.line;
			wr_data.pixels <= {hi_byte, beat.data};
		end
	end

	// One write per two video bytes at most
	assert property (@(posedge clk125) disable iff (sys_rst)
		wr_en |=> !wr_en);

endmodule

/* aux/aux_unpacker.sv */
`timescale 1ns/10ps

module aux_unpacker import gmii_rx_pkg::*; (
	input  logic      clk125,
	input  logic      sys_rst,
	input  rx_beat_t  beat,
	output logic      wr_en,
	output aux_word_t wr_data
);

	localparam int cnt_w = $clog2(aux_block_bytes);

	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_hdr1 = 3'd1;
	localparam logic [2:0] st_hdr2 = 3'd2;
	localparam logic [2:0] st_a    = 3'd3;
	localparam logic [2:0] st_b    = 3'd4;
	localparam logic [2:0] st_c    = 3'd5;

	logic [2:0]       state;
	logic [cnt_w-1:0] byte_cnt;
	logic [11:0]      chan_id;
	logic [3:0]       blocks_left;
	logic [7:0]       lo_byte;
	logic [3:0]       nib;

	// --------------------
	// Block FSM
	// --------------------

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			state    <= st_idle;
			byte_cnt <= '0;
			wr_en    <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (beat.frame_end) begin
				state <= st_idle;
			end else if (beat.aux_byte) begin
				if (beat.aux_start) begin
					// Start byte is always header byte 1
					state <= st_hdr2;
				end else begin
					case (state)
						st_hdr1: state <= st_hdr2;
						st_hdr2: begin
							state    <= st_a;
							byte_cnt <= '0;
						end
						st_a: state <= st_b;
						st_b: begin
							state <= st_c;
							wr_en <= 1'b1;
						end
						st_c: begin
							wr_en <= 1'b1;
							if (byte_cnt != cnt_w'(aux_block_bytes - 1))
								state <= st_a;
							else if (blocks_left == 4'd1)
								state <= st_idle;
							else
								state <= st_hdr1;
						end
						default: state <= st_idle;
					endcase
					if (state == st_a || state == st_b || state == st_c)
						byte_cnt <= byte_cnt + 1'b1;
				end
			end
		end
	end

	// Channel header and sample bytes
	always_ff @(posedge clk125) begin
		if (beat.aux_byte) begin
			if (beat.aux_start || state == st_hdr1)
				chan_id[7:0] <= beat.data;
			if (!beat.aux_start) begin
				case (state)
					st_hdr2: begin
						chan_id[11:8] <= beat.data[3:0];
						blocks_left   <= beat.data[7:4];
					end
					st_a: lo_byte <= beat.data;
					st_b: begin
						nib     <= beat.data[7:4];
						wr_data <= {chan_id, beat.data[3:0], lo_byte};
					end
					st_c: wr_data <= {chan_id, beat.data, nib};
					default: ;
				endcase
			end
		end
	end

	assert property (@(posedge clk125) disable iff (sys_rst)
		wr_en |-> $past(beat.aux_byte));

endmodule

/* source/gmii_video_rx.sv */
`timescale 1ns/10ps

module gmii_video_rx import gmii_rx_pkg::*; #(
	parameter logic [31:0] local_ip       = {8'd192, 8'd168, 8'd0, 8'd1},
	parameter logic [15:0] local_port     = 16'd12345,
	parameter int          video_end      = 1332,
	parameter int          vid_fifo_depth = 1024,
	parameter int          aux_fifo_depth = 128
) (
	input  logic        clk125,
	input  logic        sys_rst,
	input  logic [7:0]  rxd,
	input  logic        rx_dv,
	input  logic        id,
	input  logic        vid_rd_en,
	output pixel_word_t vid_data,
	output logic        vid_empty,
	output logic        vid_overflow,
	input  logic        aux_rd_en,
	output aux_word_t   aux_data,
	output logic        aux_empty,
	output logic        aux_overflow
);

	rx_beat_t    beat;
	line_info_t  line_info;
	logic        vid_wr_en;
	pixel_word_t vid_wr_data;
	logic        aux_wr_en;
	aux_word_t   aux_wr_data;

	udp_header_match #(
		.local_ip   (local_ip),
		.local_port (local_port),
		.video_end  (video_end)
	) udp_header_match_i (
		.clk125   (clk125),
		.sys_rst  (sys_rst),
		.rxd      (rxd),
		.rx_dv    (rx_dv),
		.id       (id),
		.beat     (beat),
		.line_out (line_info)
	);

	video_packer video_packer_i (
		.clk125  (clk125),
		.sys_rst (sys_rst),
		.beat    (beat),
		.line_in (line_info),
		.wr_en   (vid_wr_en),
		.wr_data (vid_wr_data)
	);

	aux_unpacker aux_unpacker_i (
		.clk125  (clk125),
		.sys_rst (sys_rst),
		.beat    (beat),
		.wr_en   (aux_wr_en),
		.wr_data (aux_wr_data)
	);

	// --------------------
	// Output FIFOs
	// --------------------

	sync_fifo #(
		.width ($bits(pixel_word_t)),
		.depth (vid_fifo_depth)
	) vid_fifo_i (
		.clk125   (clk125),
		.sys_rst  (sys_rst),
		.wr_en    (vid_wr_en),
		.wr_data  (vid_wr_data),
		.rd_en    (vid_rd_en),
		.rd_data  (vid_data),
		.empty    (vid_empty),
		.overflow (vid_overflow)
	);

	sync_fifo #(
		.width ($bits(aux_word_t)),
		.depth (aux_fifo_depth)
	) aux_fifo_i (
		.clk125   (clk125),
		.sys_rst  (sys_rst),
		.wr_en    (aux_wr_en),
		.wr_data  (aux_wr_data),
		.rd_en    (aux_rd_en),
		.rd_data  (aux_data),
		.empty    (aux_empty),
		.overflow (aux_overflow)
	);

endmodule

/* test/tb_gmii_video_rx.sv */
`timescale 1ns/10ps

module tb_gmii_video_rx import gmii_rx_pkg::*;;

	localparam logic [31:0] tb_ip     = {8'd10, 8'd0, 8'd0, 8'd20};
	localparam logic [15:0] tb_port   = 16'd5004;
	localparam int          vid_end   = 1332;
	localparam int          vid_depth = 512;
	localparam int          aux_depth = 128;
	localparam int          blk_len   = aux_block_bytes + 2;
	// Four long frames with the overflow drain plus six short audio frames
	localparam int          max_cycles = 5 * 1400 + 6 * 200 + 1000;

	logic        clk125 = 1'b0;
	logic        sys_rst;
	logic [7:0]  rxd;
	logic        rx_dv;
	logic        id;
	logic        vid_rd_en;
	pixel_word_t vid_data;
	logic        vid_empty;
	logic        vid_overflow;
	logic        aux_rd_en;
	aux_word_t   aux_data;
	logic        aux_empty;
	logic        aux_overflow;

	integer      seed = 61356;
	int          cycle_count = 0;
	logic        drain_on;
	int          vid_reads;
	int          aux_reads;
	logic [7:0]  frame [0:2047];
	pixel_word_t vid_exp [$];
	aux_word_t   aux_exp [$];

	gmii_video_rx #(
		.local_ip       (tb_ip),
		.local_port     (tb_port),
		.video_end      (vid_end),
		.vid_fifo_depth (vid_depth),
		.aux_fifo_depth (aux_depth)
	) gmii_video_rx_i (
		.clk125       (clk125),
		.sys_rst      (sys_rst),
		.rxd          (rxd),
		.rx_dv        (rx_dv),
		.id           (id),
		.vid_rd_en    (vid_rd_en),
		.vid_data     (vid_data),
		.vid_empty    (vid_empty),
		.vid_overflow (vid_overflow),
		.aux_rd_en    (aux_rd_en),
		.aux_data     (aux_data),
		.aux_empty    (aux_empty),
		.aux_overflow (aux_overflow)
	);

	always #10 clk125 = ~clk125;

	always @(posedge clk125) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout: the run went past %0d cycles", max_cycles);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	// --------------------
	// Checks and helpers
	// --------------------

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abort_run(input string what);
		$display("Error at %0t: %s", $time, what);
		$display("RESULT: FAIL");
		$fatal(1, "run aborted");
	endtask

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// Both FIFOs are popped and compared whenever draining is on
	always @(posedge clk125) begin
		#2;
		vid_rd_en = drain_on && !vid_empty;
		aux_rd_en = drain_on && !aux_empty;
		if (vid_rd_en) begin
			if (vid_exp.size() == 0) begin
				abort_run("pixel word in the video FIFO with none expected");
			end else begin
				check_value("vid_data", vid_data, vid_exp.pop_front());
				vid_reads++;
			end
		end
		if (aux_rd_en) begin
			if (aux_exp.size() == 0) begin
				abort_run("sample word in the audio FIFO with none expected");
			end else begin
				check_value("aux_data", aux_data, aux_exp.pop_front());
				aux_reads++;
			end
		end
	end

	task automatic wait_drained();
		do begin
			@(posedge clk125);
			#3;
		end while (!(vid_empty && aux_empty));
		check_value("vid_pending", vid_exp.size(), 0);
		check_value("aux_pending", aux_exp.size(), 0);
	endtask

	// --------------------
	// Frame builder
	// --------------------

	task automatic send_frame(input logic [15:0] eth_type, input logic [31:0] dst_ip,
			input logic [15:0] dst_port, input logic [7:0] kind, input int nblk,
			input int extra, input int cut);
		int          i;
		int          p;
		int          h;
		int          blk;
		int          len;
		int          aux_at;
		logic [10:0] line;
		logic        odd;
		logic        accept;
		logic        has_video;
		logic        has_aux;
		logic [7:0]  tmp;
		logic [11:0] chan;
		pixel_word_t pw;
		aux_word_t   aw;

		for (i = 0; i < 7; i++)
			frame[i] = 8'h55;
		frame[7] = 8'hd5;
		for (i = 8; i < off_info; i++)
			frame[i] = rand_byte();
		frame[off_eth_type]     = eth_type[15:8];
		frame[off_eth_type + 1] = eth_type[7:0];
		frame[off_ip_ver]       = 8'h45;
		frame[off_ip_proto]     = 8'd17;
		for (i = 0; i < 4; i++)
			frame[off_ip_dst + i] = dst_ip[31 - 8 * i -: 8];
		frame[off_udp_dst]     = dst_port[15:8];
		frame[off_udp_dst + 1] = dst_port[7:0];
		frame[off_info]        = kind;

		has_video = kind == kind_video || kind == kind_vidax;
		has_aux   = kind == kind_audio || kind == kind_vidax;
		aux_at    = has_video ? vid_end : off_payload;

		// Bit 3 of the second prologue byte is don't care
		line[7:0]  = rand_byte();
		tmp        = rand_byte();
		line[10:8] = tmp[2:0];
		odd        = tmp[4];
		if (has_video) begin
			frame[off_payload]     = line[7:0];
			frame[off_payload + 1] = tmp;
			for (i = off_payload + 2; i < vid_end; i++)
				frame[i] = rand_byte();
		end

		for (blk = 0; blk < nblk; blk++) begin
			h        = aux_at + blk * blk_len;
			frame[h] = rand_byte();
			tmp      = rand_byte();
			frame[h + 1] = {4'(nblk - blk), tmp[3:0]};
			for (i = h + 2; i < h + blk_len; i++)
				frame[i] = rand_byte();
		end
		len = aux_at + nblk * blk_len + extra;
		for (i = len - extra; i < len; i++)
			frame[i] = rand_byte();
		if (cut > 0)
			len = cut;

		// Expected words cover only pairs and samples sent before rx_dv falls
		accept = eth_type == eth_type_ipv4 && dst_ip == tb_ip + 32'(id) &&
			dst_port == tb_port && (has_video || has_aux);
		if (accept && has_video) begin
			for (p = off_payload + 2; p + 1 < vid_end && p + 1 < len; p += 2) begin
				pw = {odd, line, frame[p], frame[p + 1]};
				vid_exp.push_back(pw);
			end
		end
		if (accept && has_aux) begin
			for (blk = 0; blk < nblk; blk++) begin
				h    = aux_at + blk * blk_len;
				tmp  = frame[h + 1];
				chan = {tmp[3:0], frame[h]};
				for (i = h + 2; i < h + blk_len; i += 3) begin
					tmp = frame[i + 1];
					if (i + 1 < len) begin
						aw = {chan, tmp[3:0], frame[i]};
						aux_exp.push_back(aw);
					end
					if (i + 2 < len) begin
						aw = {chan, frame[i + 2], tmp[7:4]};
						aux_exp.push_back(aw);
					end
				end
			end
		end

		for (i = 0; i < len; i++) begin
			@(posedge clk125);
			#2;
			rx_dv = 1'b1;
			rxd   = frame[i];
		end
		@(posedge clk125);
		#2;
		rx_dv = 1'b0;
		rxd   = 8'h00;
		repeat (12) @(posedge clk125);
		#2;
	endtask

	// --------------------
	// Directed tests
	// --------------------

	task automatic accept_video_frame();
		vid_reads = 0;
		send_frame(eth_type_ipv4, tb_ip, tb_port, kind_video, 0, 3, 0);
		wait_drained();
		check_value("vid_reads", vid_reads, (vid_end - off_payload - 2) / 2);
	endtask

	task automatic filter_addresses();
		aux_reads = 0;
		id = 1'b0;
		send_frame(eth_type_ipv4, tb_ip, tb_port + 16'd1, kind_audio, 2, 0, 0);
		send_frame(eth_type_ipv4, tb_ip + 32'd5, tb_port, kind_audio, 2, 0, 0);
		id = 1'b1;
		send_frame(eth_type_ipv4, tb_ip, tb_port, kind_audio, 2, 0, 0);
		wait_drained();
		send_frame(eth_type_ipv4, tb_ip + 32'd1, tb_port, kind_audio, 2, 0, 0);
		wait_drained();
		check_value("aux_reads", aux_reads, 64);
		id = 1'b0;
	endtask

	task automatic unpack_audio_blocks();
		aux_reads = 0;
		send_frame(eth_type_ipv4, tb_ip, tb_port, kind_audio, 2, 7, 0);
		wait_drained();
		check_value("aux_reads", aux_reads, 64);
	endtask

	task automatic split_vidax_frame();
		vid_reads = 0;
		aux_reads = 0;
		send_frame(eth_type_ipv4, tb_ip, tb_port, kind_vidax, 2, 4, 0);
		wait_drained();
		check_value("vid_reads", vid_reads, (vid_end - off_payload - 2) / 2);
		check_value("aux_reads", aux_reads, 64);
	endtask

	task automatic recover_from_cut();
		aux_reads = 0;
		// Cut after bytes a and b of the sixth sample pair
		send_frame(eth_type_ipv4, tb_ip, tb_port, kind_vidax, 2, 0, vid_end + 2 + 17);
		wait_drained();
		check_value("aux_reads", aux_reads, 11);
		aux_reads = 0;
		send_frame(eth_type_ipv4, tb_ip, tb_port, kind_audio, 2, 0, 0);
		wait_drained();
		check_value("aux_reads", aux_reads, 64);
	endtask

	task automatic fill_until_overflow();
		int words;

		words     = (vid_end - off_payload - 2) / 2;
		vid_reads = 0;
		check_value("vid_overflow", vid_overflow, 0);
		drain_on = 1'b0;
		send_frame(eth_type_ipv4, tb_ip, tb_port, kind_video, 0, 0, 0);
		check_value("vid_overflow", vid_overflow, 1);
		check_value("aux_overflow", aux_overflow, 0);
		@(posedge clk125);
		drain_on = 1'b1;
		do begin
			@(posedge clk125);
			#3;
		end while (!vid_empty);
		check_value("vid_reads", vid_reads, vid_depth);
		check_value("vid_dropped", vid_exp.size(), words - vid_depth);
		check_value("vid_overflow", vid_overflow, 1);
		vid_exp.delete();
	endtask

	initial begin
		sys_rst   = 1'b1;
		rxd       = 8'h00;
		rx_dv     = 1'b0;
		id        = 1'b0;
		vid_rd_en = 1'b0;
		aux_rd_en = 1'b0;
		drain_on  = 1'b0;
		vid_reads = 0;
		aux_reads = 0;
		repeat (3) @(posedge clk125);
		#2;
		sys_rst = 1'b0;
		check_value("vid_empty", vid_empty, 1);
		check_value("aux_empty", aux_empty, 1);
		check_value("vid_overflow", vid_overflow, 0);
		check_value("aux_overflow", aux_overflow, 0);
		@(posedge clk125);
		drain_on = 1'b1;

		accept_video_frame();
		filter_addresses();
		unpack_audio_blocks();
		split_vidax_frame();
		recover_from_cut();
		// Overflow is sticky so this test runs last
		fill_until_overflow();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* src.f */
common/gmii_rx_pkg.sv
source/sync_fifo.sv
source/udp_header_match.sv
video/video_packer.sv
aux/aux_unpacker.sv
source/gmii_video_rx.sv
test/tb_gmii_video_rx.sv
